// ==== verilog/twoaddr_alu_pkg.sv ====
// ########################################
// Two-address ALU shared definitions
// Instruction format, opcodes and stage structs
// ########################################

`default_nettype none

package twoaddr_alu_pkg;

    localparam int REG_ADDR_W = 3;
    localparam int REG_COUNT  = 8;
    localparam int IMM_W      = 8;

    // Codes 4'hB to 4'hF are illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_SLL  = 4'h6,
        OP_SRL  = 4'h7,
        OP_LI   = 4'h8,
        OP_MOV  = 4'h9,
        OP_NOP  = 4'hA
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLL    = 3'd5,
        ALU_SRL    = 3'd6,
        ALU_PASS_B = 3'd7
    } alu_op_e;

    // rd is both first source and destination
    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs2;
        logic [IMM_W-1:0]      imm;
    } instr_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  writes;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs2;
        logic [IMM_W-1:0]      imm;
    } decoded_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  illegal;
    } result_info_t;

endpackage

`default_nettype wire

// ==== verilog/common_dffram_2a1w2r.sv ====
// ########################################
// Flip-flop register file, 2 address ports
// Port A read-first read/write, port B read only
// ########################################

`timescale 1ns/10ps
`default_nettype none

module common_dffram_2a1w2r #(
    parameter int RAM_DATA_WIDTH = 32,
    parameter int RAM_DEPTH      = 8,
    localparam int RAM_ADDR_WIDTH = $clog2(RAM_DEPTH)
) (
    input  logic                        clk,
    input  logic                        reset,

    // Port A reads and writes
    input  logic [RAM_ADDR_WIDTH-1:0]   addra,
    input  logic                        ena,
    input  logic                        wea,
    input  logic [RAM_DATA_WIDTH-1:0]   dina,
    output logic [RAM_DATA_WIDTH-1:0]   douta,

    // Port B only reads
    input  logic [RAM_ADDR_WIDTH-1:0]   addrb,
    output logic [RAM_DATA_WIDTH-1:0]   doutb
);

    logic [RAM_DATA_WIDTH-1:0] mem [RAM_DEPTH];
    logic [RAM_DEPTH-1:0]      sel_a;
    logic [RAM_DEPTH-1:0]      sel_b;

    // One-hot address decode
    always_comb begin
        sel_a = '0;
        sel_b = '0;
        sel_a[addra] = 1'b1;
        sel_b[addrb] = 1'b1;
    end

    genvar i;
    generate
        for (i = 0; i < RAM_DEPTH; i = i + 1) begin : gen_entry
            always_ff @(posedge clk) begin
                if (reset) begin
                    mem[i] <= '0;
                end else if (ena && wea && sel_a[i]) begin
                    mem[i] <= dina;
                end
            end
        end
    endgenerate

    // AND-OR read muxes
    // Port A sees the stored value, so a write shows up only next cycle
    always_comb begin
        douta = '0;
        doutb = '0;
        for (int j = 0; j < RAM_DEPTH; j++) begin
            douta = douta | (mem[j] & {RAM_DATA_WIDTH{sel_a[j]}});
            doutb = doutb | (mem[j] & {RAM_DATA_WIDTH{sel_b[j]}});
        end
    end

    // Both ports must address a real entry while port A is enabled
    a_addr_range: assert property (
        @(posedge clk) disable iff (reset)
        ena |-> (int'(addra) < RAM_DEPTH) && (int'(addrb) < RAM_DEPTH)
    ) else $error("regfile address out of range: a=%0d b=%0d", addra, addrb);

endmodule

`default_nettype wire

// ==== verilog/twoaddr_decode.sv ====
// ########################################
// Two-address decode stage
// Registers the instruction and classifies it
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_decode
    import twoaddr_alu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     dec_valid,
    output decoded_t dec
);

    decoded_t dec_next;

    always_comb begin
        dec_next         = '0;
        dec_next.rd      = instr.rd;
        dec_next.rs2     = instr.rs2;
        dec_next.imm     = instr.imm;
        dec_next.writes  = 1'b1;
        dec_next.alu_op  = ALU_PASS_B;
        case (instr.opcode)
            OP_ADD: dec_next.alu_op = ALU_ADD;
            OP_SUB: dec_next.alu_op = ALU_SUB;
            OP_AND: dec_next.alu_op = ALU_AND;
            OP_OR:  dec_next.alu_op = ALU_OR;
            OP_XOR: dec_next.alu_op = ALU_XOR;
            OP_SLL: dec_next.alu_op = ALU_SLL;
            OP_SRL: dec_next.alu_op = ALU_SRL;
            OP_MOV: dec_next.alu_op = ALU_PASS_B;
            OP_ADDI: begin
                dec_next.alu_op  = ALU_ADD;
                dec_next.use_imm = 1'b1;
            end
            OP_LI: begin
                dec_next.alu_op  = ALU_PASS_B;
                dec_next.use_imm = 1'b1;
            end
            OP_NOP: dec_next.writes = 1'b0;
            default: begin
                dec_next.writes  = 1'b0;
                dec_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Payload only loads on a valid instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec <= dec_next;
        end
    end

    a_illegal_no_write: assert property (
        @(posedge clk) disable iff (reset)
        dec_valid |-> !(dec.illegal && dec.writes)
    ) else $error("decode flagged illegal instruction as writing");

endmodule

`default_nettype wire

// ==== verilog/twoaddr_execute.sv ====
// ########################################
// Two-address execute stage
// Register file reads and combinational ALU
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_execute
    import twoaddr_alu_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  dec_valid,
    input  decoded_t              dec,

    // Register file read side
    output logic [REG_ADDR_W-1:0] addra,
    output logic [REG_ADDR_W-1:0] addrb,
    input  logic [DATA_WIDTH-1:0] douta,
    input  logic [DATA_WIDTH-1:0] doutb,

    output logic                  exe_valid,
    output decoded_t              exe,
    output logic [DATA_WIDTH-1:0] exe_value
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] imm_ext;
    logic [DATA_WIDTH-1:0] opb;
    logic [SHAMT_W-1:0]    shamt;
    logic [DATA_WIDTH-1:0] alu_out;

    // rd is the first source as well as the destination
    assign addra = dec.rd;
    assign addrb = dec.rs2;

    assign imm_ext = {{(DATA_WIDTH - IMM_W){dec.imm[IMM_W-1]}}, dec.imm};
    assign opb     = dec.use_imm ? imm_ext : doutb;

    // Shifts only look at the low bits of operand B
    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_out = douta + opb;
            ALU_SUB:    alu_out = douta - opb;
            ALU_AND:    alu_out = douta & opb;
            ALU_OR:     alu_out = douta | opb;
            ALU_XOR:    alu_out = douta ^ opb;
            ALU_SLL:    alu_out = douta << shamt;
            ALU_SRL:    alu_out = douta >> shamt;
            ALU_PASS_B: alu_out = opb;
            default:    alu_out = '0;
        endcase
    end

    assign exe_valid = dec_valid;
    assign exe       = dec;
    assign exe_value = alu_out;

endmodule

`default_nettype wire

// ==== verilog/twoaddr_result.sv ====
// ########################################
// Two-address result stage
// Write-back controls and retired outputs
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_result
    import twoaddr_alu_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exe_valid,
    input  decoded_t              exe,
    input  logic [DATA_WIDTH-1:0] exe_value,

    // Write-back through register file port A
    output logic                  ena,
    output logic                  wea,
    output logic [DATA_WIDTH-1:0] dina,

    output logic                  result_valid,
    output result_info_t          result_info,
    output logic [DATA_WIDTH-1:0] result_data
);

    // The write lands on the same edge that retires the instruction
    assign ena  = exe_valid;
    assign wea  = exe_valid & exe.writes;
    assign dina = exe_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exe_valid;
        end
    end

    // NOP and illegal retire with zero data
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            result_info.rd      <= exe.rd;
            result_info.illegal <= exe.illegal;
            result_data         <= exe.writes ? exe_value : '0;
        end
    end

    // Decode clears its valid on reset, so no write can follow a reset edge
    a_no_write_in_reset: assert property (
        @(posedge clk) reset |=> !wea
    ) else $error("register write issued during reset");

endmodule

`default_nettype wire

// ==== verilog/twoaddr_alu_top.sv ====
// ########################################
// Two-address integer datapath top level
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_alu_top
    import twoaddr_alu_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  instr_t                instr,
    output logic                  result_valid,
    output result_info_t          result_info,
    output logic [DATA_WIDTH-1:0] result_data
);

    logic                  dec_valid;
    decoded_t              dec;
    logic                  exe_valid;
    decoded_t              exe;
    logic [DATA_WIDTH-1:0] exe_value;

    // Register file ports
    logic [REG_ADDR_W-1:0] addra;
    logic [REG_ADDR_W-1:0] addrb;
    logic [DATA_WIDTH-1:0] douta;
    logic [DATA_WIDTH-1:0] doutb;
    logic                  ena;
    logic                  wea;
    logic [DATA_WIDTH-1:0] dina;

    twoaddr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    twoaddr_execute #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_execute (
        .dec_valid (dec_valid),
        .dec       (dec),
        .addra     (addra),
        .addrb     (addrb),
        .douta     (douta),
        .doutb     (doutb),
        .exe_valid (exe_valid),
        .exe       (exe),
        .exe_value (exe_value)
    );

    twoaddr_result #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_result (
        .clk          (clk),
        .reset        (reset),
        .exe_valid    (exe_valid),
        .exe          (exe),
        .exe_value    (exe_value),
        .ena          (ena),
        .wea          (wea),
        .dina         (dina),
        .result_valid (result_valid),
        .result_info  (result_info),
        .result_data  (result_data)
    );

    common_dffram_2a1w2r #(
        .RAM_DATA_WIDTH (DATA_WIDTH),
        .RAM_DEPTH      (REG_COUNT)
    ) u_regfile (
        .clk   (clk),
        .reset (reset),
        .addra (addra),
        .ena   (ena),
        .wea   (wea),
        .dina  (dina),
        .douta (douta),
        .addrb (addrb),
        .doutb (doutb)
    );

endmodule

`default_nettype wire

// ==== bench/twoaddr_alu_checker.sv ====
// ########################################
// Two-address ALU result checker
// Reference register model and in-order compare
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_alu_checker
    import twoaddr_alu_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  instr_t                instr,
    input  logic [7:0]            test_id,
    input  logic                  test_end,
    input  logic                  run_end,
    input  logic                  result_valid,
    input  result_info_t          result_info,
    input  logic [DATA_WIDTH-1:0] result_data,
    output int                    pending,
    output int                    error_count
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    typedef struct packed {
        logic [7:0]            test_id;
        result_info_t          info;
        logic [DATA_WIDTH-1:0] data;
    } expect_t;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    expect_t               exp_q [$];
    int                    test_checks;
    int                    test_errors;
    int                    total_checks;
    int                    tests_passed;
    int                    tests_failed;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "reset_zero";
            8'd2:    return "alu_ops";
            8'd3:    return "back_to_back";
            8'd4:    return "illegal_nop";
            8'd5:    return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic is_legal(input opcode_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI,
            OP_SLL, OP_SRL, OP_LI, OP_MOV, OP_NOP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected write-back value with zero for NOP and illegal codes
    function automatic logic [DATA_WIDTH-1:0] ref_result(
        input opcode_e               op,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b,
        input logic [IMM_W-1:0]      imm
    );
        logic [DATA_WIDTH-1:0] sext;
        int                    sh;
        sext = {{(DATA_WIDTH - IMM_W){imm[IMM_W-1]}}, imm};
        sh   = int'(b[SHAMT_W-1:0]);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + sext;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_LI:   return sext;
            OP_MOV:  return b;
            default: return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        expect_t               e;
        logic [DATA_WIDTH-1:0] val;
        logic                  writes;
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] = '0;
            end
            exp_q.delete();
        end else begin
            // Compare before accepting since an instruction accepted now retires two edges later
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("result_valid seen with no instruction outstanding (rd %0d data %h)",
                             result_info.rd, result_data);
                    error_count++;
                    test_errors++;
                end else begin
                    e = exp_q.pop_front();
                    test_checks++;
                    total_checks++;
                    if (result_info !== e.info || result_data !== e.data) begin
                        $write("FAIL %s: expected rd=%0d illegal=%0b data=%h",
                               test_name(e.test_id), e.info.rd, e.info.illegal, e.data);
                        $display(", actual rd=%0d illegal=%0b data=%h",
                                 result_info.rd, result_info.illegal, result_data);
                        error_count++;
                        test_errors++;
                    end
                end
            end

            if (instr_valid) begin
                val    = ref_result(instr.opcode, regs[instr.rd], regs[instr.rs2], instr.imm);
                writes = is_legal(instr.opcode) && (instr.opcode != OP_NOP);
                if (writes) begin
                    regs[instr.rd] = val;
                end
                e.test_id      = test_id;
                e.info.rd      = instr.rd;
                e.info.illegal = !is_legal(instr.opcode);
                e.data         = writes ? val : '0;
                exp_q.push_back(e);
            end

            if (test_end) begin
                if (test_errors == 0 && test_checks > 0) begin
                    $display("test %s: passed, %0d results", test_name(test_id), test_checks);
                    tests_passed++;
                end else begin
                    $display("test %s: failed, %0d errors in %0d results",
                             test_name(test_id), test_errors, test_checks);
                    tests_failed++;
                end
                test_checks = 0;
                test_errors = 0;
            end

            if (run_end) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected results never retired", exp_q.size());
                    error_count += exp_q.size();
                end
                $display("tests: %0d passed, %0d failed; results: %0d checked, %0d errors",
                         tests_passed, tests_failed, total_checks, error_count);
            end
        end
        pending = exp_q.size();
    end

    initial begin
        pending      = 0;
        error_count  = 0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

endmodule

`default_nettype wire

// ==== bench/twoaddr_alu_tb.sv ====
// ########################################
// Two-address ALU testbench
// Directed and random instruction streams
// ########################################

`timescale 1ns/10ps
`default_nettype none

module twoaddr_alu_tb
    import twoaddr_alu_pkg::*;
();

    localparam int DATA_WIDTH      = 32;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_INSTRS = 53;
    localparam int RANDOM_INSTRS   = 300;
    localparam int DRAIN_LIMIT     = 20;
    localparam int WATCHDOG_CYCLES = 20 * (DIRECTED_INSTRS + RANDOM_INSTRS) + 100;

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    instr_t                instr;
    logic                  result_valid;
    result_info_t          result_info;
    logic [DATA_WIDTH-1:0] result_data;

    logic [7:0]            test_id;
    logic                  test_end;
    logic                  run_end;
    int                    pending;
    int                    error_count;
    int                    drain_errors;
    int                    issued;
    int                    seed;

    twoaddr_alu_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_info  (result_info),
        .result_data  (result_data)
    );

    twoaddr_alu_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .test_id      (test_id),
        .test_end     (test_end),
        .run_end      (run_end),
        .result_valid (result_valid),
        .result_info  (result_info),
        .result_data  (result_data),
        .pending      (pending),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // Drives one instruction for one cycle, starting at a falling edge
    task automatic issue(input logic [3:0] op, input logic [2:0] rd, input logic [2:0] rs2,
                         input logic [7:0] imm);
        instr_valid  = 1'b1;
        instr.opcode = opcode_e'(op);
        instr.rd     = rd;
        instr.rs2    = rs2;
        instr.imm    = imm;
        issued++;
        @(negedge clk);
    endtask

    task automatic idle(input int cycles);
        instr_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // Waits for the outstanding results, then lets the checker close the test
    task automatic finish_test();
        int waited;
        waited      = 0;
        instr_valid = 1'b0;
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("test %0d: %0d results still missing after %0d cycles",
                     test_id, pending, DRAIN_LIMIT);
            drain_errors++;
        end
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    task automatic reset_read_back();
        test_id = 8'd1;
        for (int i = 0; i < REG_COUNT; i++) begin
            issue(OP_MOV, i[2:0], i[2:0], 8'h00);
        end
        finish_test();
    endtask

    task automatic alu_op_walk();
        test_id = 8'd2;
        issue(OP_LI, 3'd1, 3'd0, 8'h7f);
        issue(OP_LI, 3'd2, 3'd0, 8'h80);
        issue(OP_LI, 3'd3, 3'd0, 8'h05);
        issue(OP_LI, 3'd4, 3'd0, 8'hfd);
        issue(OP_LI, 3'd5, 3'd0, 8'h3c);
        issue(OP_LI, 3'd6, 3'd0, 8'he1);
        issue(OP_ADD, 3'd1, 3'd2, 8'h00);
        issue(OP_SUB, 3'd3, 3'd4, 8'h00);
        issue(OP_AND, 3'd5, 3'd6, 8'h00);
        issue(OP_OR, 3'd6, 3'd2, 8'h00);
        issue(OP_XOR, 3'd4, 3'd1, 8'h00);
        // r1 is all ones here, so this wraps to zero
        issue(OP_ADDI, 3'd1, 3'd0, 8'h01);
        issue(OP_ADDI, 3'd2, 3'd0, 8'h80);
        issue(OP_SLL, 3'd5, 3'd3, 8'h00);
        issue(OP_SRL, 3'd2, 3'd3, 8'h00);
        issue(OP_LI, 3'd7, 3'd0, 8'h23);
        issue(OP_SLL, 3'd6, 3'd7, 8'h00);
        finish_test();
    endtask

    task automatic dependent_chain();
        test_id = 8'd3;
        issue(OP_LI, 3'd3, 3'd0, 8'h01);
        repeat (5) issue(OP_ADD, 3'd3, 3'd3, 8'h00);
        issue(OP_ADDI, 3'd3, 3'd0, 8'hff);
        issue(OP_MOV, 3'd0, 3'd3, 8'h00);
        issue(OP_ADD, 3'd0, 3'd3, 8'h00);
        issue(OP_SUB, 3'd3, 3'd0, 8'h00);
        finish_test();
    endtask

    task automatic illegal_and_nop();
        logic [3:0] code;
        test_id = 8'd4;
        for (int i = 0; i < 5; i++) begin
            issue(OP_LI, i[2:0] + 3'd1, 3'd0, 8'h40 + i[7:0]);
        end
        for (int i = 0; i < 5; i++) begin
            code = 4'hB + i[3:0];
            issue(code, i[2:0] + 3'd1, i[2:0], 8'h11);
        end
        issue(OP_LI, 3'd6, 3'd0, 8'h66);
        issue(OP_NOP, 3'd6, 3'd0, 8'h22);
        for (int i = 1; i <= 6; i++) begin
            issue(OP_MOV, i[2:0], i[2:0], 8'h00);
        end
        finish_test();
    endtask

    task automatic random_stream();
        int r;
        test_id = 8'd5;
        for (int n = 0; n < RANDOM_INSTRS; n++) begin
            r = $random(seed);
            issue(r[3:0], r[6:4], r[9:7], r[17:10]);
            // About one instruction in four is followed by a short gap
            if (r[19:18] == 2'b00) begin
                idle(1 + int'(r[21:20]));
            end
        end
        finish_test();
    endtask

    initial begin
        seed         = 32'h164c;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        test_id      = 8'd0;
        test_end     = 1'b0;
        run_end      = 1'b0;
        drain_errors = 0;
        issued       = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle(2);

        reset_read_back();
        alu_op_walk();
        dependent_chain();
        illegal_and_nop();
        random_stream();

        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
        @(negedge clk);

        $display("%0d instructions issued", issued);
        if (error_count == 0 && drain_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== twoaddr_alu.f ====
verilog/twoaddr_alu_pkg.sv
verilog/common_dffram_2a1w2r.sv
verilog/twoaddr_decode.sv
verilog/twoaddr_execute.sv
verilog/twoaddr_result.sv
verilog/twoaddr_alu_top.sv
bench/twoaddr_alu_checker.sv
bench/twoaddr_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the two-address ALU testbench with Verilator and runs it

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module twoaddr_alu_tb \
    -f twoaddr_alu.f

./obj_dir/Vtwoaddr_alu_tb | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed, see sim.log"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
